//--- common/trace_macros.svh
// Pipeline trace sizing
// Table depth, tag width and data width shared by the package and the RTL

`ifndef TRACE_MACROS_SVH
`define TRACE_MACROS_SVH

// Entries in the record table
// Must exceed the five instructions that can be in flight
`define TRACE_DEPTH 8

// Tag width, tags wrap modulo the table depth
`define TRACE_TAG_W 3

// Width of pc, instruction word and data fields
`define TRACE_DATA_W 32

`endif

//--- common/trace_pkg.sv
// Shared types for the pipeline trace unit
// Per-stage observations, tag pipe state and the retire record

`include "trace_macros.svh"

package trace_pkg;

    // Instruction class as reported by decode
    typedef enum logic [3:0] {
        op_alu     = 4'd0,
        op_alu_imm = 4'd1,
        op_load    = 4'd2,
        op_store   = 4'd3,
        op_branch  = 4'd4,
        op_jump    = 4'd5,
        op_nop     = 4'd6
    } opcode_e;

    //////////////////////////////////////////////////
    // Stage observations
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`TRACE_DATA_W-1:0] pc;
    } fetch_obs_t;

    typedef struct packed {
        logic [`TRACE_DATA_W-1:0] instr;
        opcode_e                  opcode;
    } decode_obs_t;

    typedef struct packed {
        logic [`TRACE_DATA_W-1:0] alu_result;
    } exec_obs_t;

    // Accessed is low for instructions that skip memory
    typedef struct packed {
        logic [`TRACE_DATA_W-1:0] addr;
        logic                     accessed;
    } mem_obs_t;

    typedef struct packed {
        logic [4:0]               rd;
        logic                     we;
        logic [`TRACE_DATA_W-1:0] data;
    } wb_obs_t;

    //////////////////////////////////////////////////
    // Tag pipe state and retire record
    //////////////////////////////////////////////////

    // One pipeline slot
    typedef struct packed {
        logic                    valid;
        logic [`TRACE_TAG_W-1:0] tag;
    } stage_slot_t;

    typedef struct packed {
        stage_slot_t f;
        stage_slot_t d;
        stage_slot_t e;
        stage_slot_t m;
        stage_slot_t w;
    } stage_state_t;

    // Complete history of one retired instruction
    typedef struct packed {
        logic [`TRACE_TAG_W-1:0] tag;
        fetch_obs_t              fetch;
        decode_obs_t             decode;
        exec_obs_t               exec;
        mem_obs_t                mem;
        wb_obs_t                 wb;
        logic [31:0]             retire_cycle;
    } retire_rec_t;

endpackage

//--- trace/trace_tag_pipe.sv
// Tag pipe of the pipeline trace unit
// Follows which of the five stages hold live instructions and their tags,
// honoring stall and flush with flush taking priority

`include "trace_macros.svh"

module trace_tag_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    flush,
    output trace_pkg::stage_state_t stages
);

    // Tag carried by the instruction now in fetch
    // Also the tag that the next new fetch takes
    logic [`TRACE_TAG_W-1:0] next_tag_q;

    // Registered slots behind fetch
    trace_pkg::stage_slot_t d_q;
    trace_pkg::stage_slot_t e_q;
    trace_pkg::stage_slot_t m_q;
    trace_pkg::stage_slot_t w_q;

    // New fetch enters unless a stall holds F
    logic fetch_adv;

    assign fetch_adv = flush || !stall;

    //////////////////////////////////////////////////
    // Fetch counter
    //////////////////////////////////////////////////

    // Wraps at the table depth by width
    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag_q <= '0;
        end else if (fetch_adv) begin
            next_tag_q <= next_tag_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Stage registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            d_q <= '0;
            e_q <= '0;
            m_q <= '0;
            w_q <= '0;
        end else begin
            // Back half always drains
            w_q <= m_q;
            m_q <= e_q;
            if (flush) begin
                // F and D are killed, nothing passes to E
                d_q.valid <= 1'b0;
                e_q.valid <= 1'b0;
            end else if (stall) begin
                // F and D hold, E takes a bubble
                e_q.valid <= 1'b0;
            end else begin
                e_q       <= d_q;
                d_q.valid <= 1'b1;
                d_q.tag   <= next_tag_q;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stage view
    //////////////////////////////////////////////////

    // Fetch issues in every cycle out of reset
    assign stages.f.valid = !rst;
    assign stages.f.tag   = next_tag_q;
    assign stages.d       = d_q;
    assign stages.e       = e_q;
    assign stages.m       = m_q;
    assign stages.w       = w_q;

endmodule

//--- trace/trace_record_table.sv
// Record table of the pipeline trace unit
// Stores what fetch, decode, execute and memory observed for each tag
// and reads back the history of the instruction now in writeback

`include "trace_macros.svh"

module trace_record_table (
    input  logic                    clk,
    input  trace_pkg::fetch_obs_t   fetch_obs,
    input  trace_pkg::decode_obs_t  decode_obs,
    input  trace_pkg::exec_obs_t    exec_obs,
    input  trace_pkg::mem_obs_t     mem_obs,
    input  trace_pkg::stage_state_t stages,
    output trace_pkg::retire_rec_t  table_rec
);

    // One field array per stage, indexed by tag
    trace_pkg::fetch_obs_t  fetch_mem  [`TRACE_DEPTH];
    trace_pkg::decode_obs_t decode_mem [`TRACE_DEPTH];
    trace_pkg::exec_obs_t   exec_mem   [`TRACE_DEPTH];
    trace_pkg::mem_obs_t    mem_mem    [`TRACE_DEPTH];

    //////////////////////////////////////////////////
    // Capture
    //////////////////////////////////////////////////

    // Each live stage files its observation under its own tag
    // Stalled F and D rewrite the same entry with the held data
    always_ff @(posedge clk) begin
        if (stages.f.valid) begin
            fetch_mem[stages.f.tag] <= fetch_obs;
        end
        if (stages.d.valid) begin
            decode_mem[stages.d.tag] <= decode_obs;
        end
        if (stages.e.valid) begin
            exec_mem[stages.e.tag] <= exec_obs;
        end
        if (stages.m.valid) begin
            mem_mem[stages.m.tag] <= mem_obs;
        end
    end

    //////////////////////////////////////////////////
    // Readout at the writeback tag
    //////////////////////////////////////////////////

    // M wrote its entry one edge earlier, so W sees all four fields
    // Tag, writeback and cycle are filled in by the retire block
    always_comb begin
        table_rec        = '0;
        table_rec.fetch  = fetch_mem[stages.w.tag];
        table_rec.decode = decode_mem[stages.w.tag];
        table_rec.exec   = exec_mem[stages.w.tag];
        table_rec.mem    = mem_mem[stages.w.tag];
    end

endmodule

//--- trace/trace_retire.sv
// Retire block of the pipeline trace unit
// Counts cycles and registers one complete record per instruction
// leaving writeback

module trace_retire (
    input  logic                    clk,
    input  logic                    rst,
    input  trace_pkg::stage_state_t stages,
    input  trace_pkg::retire_rec_t  table_rec,
    input  trace_pkg::wb_obs_t      wb_obs,
    output logic                    retire_valid,
    output trace_pkg::retire_rec_t  retire_rec
);

    // Zero in the first cycle after reset
    logic [31:0] cycle_q;

    trace_pkg::retire_rec_t rec_next;

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_q      <= '0;
            retire_valid <= 1'b0;
        end else begin
            cycle_q      <= cycle_q + 1'b1;
            // One strobe per live writeback, bubbles give none
            retire_valid <= stages.w.valid;
        end
    end

    //////////////////////////////////////////////////
    // Record assembly
    //////////////////////////////////////////////////

    // Stored history plus the live writeback view
    always_comb begin
        rec_next              = table_rec;
        rec_next.tag          = stages.w.tag;
        rec_next.wb           = wb_obs;
        rec_next.retire_cycle = cycle_q;
    end

    // Payload only loads on a live writeback
    always_ff @(posedge clk) begin
        if (stages.w.valid) begin
            retire_rec <= rec_next;
        end
    end

endmodule

//--- rtl/pipeline_trace.sv
// Pipeline trace unit for a five-stage in-order CPU
// Tags every instruction, records what each stage saw and emits one
// retire record as the instruction leaves writeback

module pipeline_trace (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    input  trace_pkg::fetch_obs_t  fetch_obs,
    input  trace_pkg::decode_obs_t decode_obs,
    input  trace_pkg::exec_obs_t   exec_obs,
    input  trace_pkg::mem_obs_t    mem_obs,
    input  trace_pkg::wb_obs_t     wb_obs,
    output logic                   retire_valid,
    output trace_pkg::retire_rec_t retire_rec
);

    // Live slots and tags, shared by table and retire
    trace_pkg::stage_state_t stages;

    // Stored history for the writeback tag
    trace_pkg::retire_rec_t table_rec;

    //////////////////////////////////////////////////
    // Tag tracking
    //////////////////////////////////////////////////

    trace_tag_pipe u_tag_pipe (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .stages (stages)
    );

    //////////////////////////////////////////////////
    // Observation storage
    //////////////////////////////////////////////////

    trace_record_table u_record_table (
        .clk        (clk),
        .fetch_obs  (fetch_obs),
        .decode_obs (decode_obs),
        .exec_obs   (exec_obs),
        .mem_obs    (mem_obs),
        .stages     (stages),
        .table_rec  (table_rec)
    );

    //////////////////////////////////////////////////
    // Retire output
    //////////////////////////////////////////////////

    trace_retire u_retire (
        .clk          (clk),
        .rst          (rst),
        .stages       (stages),
        .table_rec    (table_rec),
        .wb_obs       (wb_obs),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

endmodule

//--- test/trace_model.svh
// Reference model of the pipeline trace unit
// Tracks stage occupancy and tags, keeps what each stage saw
// and queues the expected retire records

`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

// Slot order, fetch first
localparam int stage_f = 0;
localparam int stage_d = 1;
localparam int stage_e = 2;
localparam int stage_m = 3;
localparam int stage_w = 4;

logic                    m_valid [5];
logic [`TRACE_TAG_W-1:0] m_tag   [5];
logic [`TRACE_TAG_W-1:0] m_next_tag;
int unsigned             m_cycle;

// What each stage saw, by tag
trace_pkg::fetch_obs_t  m_fetch  [`TRACE_DEPTH];
trace_pkg::decode_obs_t m_decode [`TRACE_DEPTH];
trace_pkg::exec_obs_t   m_exec   [`TRACE_DEPTH];
trace_pkg::mem_obs_t    m_mem    [`TRACE_DEPTH];

// Records due, oldest first
trace_pkg::retire_rec_t exp_q [$];

// Expected record for the instruction leaving writeback
function automatic trace_pkg::retire_rec_t expected_record(
    input logic [`TRACE_TAG_W-1:0] tag,
    input trace_pkg::wb_obs_t      wb,
    input int unsigned             cycle
);
    trace_pkg::retire_rec_t rec;
    rec.tag          = tag;
    rec.fetch        = m_fetch[tag];
    rec.decode       = m_decode[tag];
    rec.exec         = m_exec[tag];
    rec.mem          = m_mem[tag];
    rec.wb           = wb;
    rec.retire_cycle = 32'(cycle);
    return rec;
endfunction

// New instruction enters fetch with the next tag
task automatic fetch_new();
    m_valid[stage_f] = 1'b1;
    m_tag[stage_f]   = m_next_tag;
    m_next_tag       = m_next_tag + 1'b1;
endtask

// First cycle after reset: only fetch is live, with tag 0
task automatic model_reset();
    for (int i = 0; i < 5; i++) begin
        m_valid[i] = 1'b0;
        m_tag[i]   = '0;
    end
    m_next_tag = '0;
    m_cycle    = 0;
    exp_q.delete();
    fetch_new();
endtask

// One clock edge of the pipeline, using the inputs of the ending cycle
task automatic model_step();
    // Every live stage files its view under its own tag
    if (m_valid[stage_f]) m_fetch[m_tag[stage_f]] = fetch_obs;
    if (m_valid[stage_d]) m_decode[m_tag[stage_d]] = decode_obs;
    if (m_valid[stage_e]) m_exec[m_tag[stage_e]] = exec_obs;
    if (m_valid[stage_m]) m_mem[m_tag[stage_m]] = mem_obs;
    if (m_valid[stage_w]) begin
        exp_q.push_back(expected_record(m_tag[stage_w], wb_obs, m_cycle));
    end
    // Back half drains every cycle
    m_valid[stage_w] = m_valid[stage_m];
    m_tag[stage_w]   = m_tag[stage_m];
    m_valid[stage_m] = m_valid[stage_e];
    m_tag[stage_m]   = m_tag[stage_e];
    if (flush) begin
        // F and D killed, D never reaches E
        m_valid[stage_e] = 1'b0;
        m_valid[stage_d] = 1'b0;
        fetch_new();
    end else if (stall) begin
        // F and D hold, bubble into E
        m_valid[stage_e] = 1'b0;
    end else begin
        m_valid[stage_e] = m_valid[stage_d];
        m_tag[stage_e]   = m_tag[stage_d];
        m_valid[stage_d] = m_valid[stage_f];
        m_tag[stage_d]   = m_tag[stage_f];
        fetch_new();
    end
    m_cycle++;
endtask

`endif

//--- test/tb_pipeline_trace.sv
// Testbench for the pipeline trace unit
// Plays a five-stage CPU with random observations, stall and flush,
// and checks every retire record against the reference model

`include "trace_macros.svh"

module tb_pipeline_trace;

    // Test lengths in cycles
    localparam int len_steady = 20;
    localparam int len_stall  = 60;
    localparam int len_flush  = 60;
    localparam int len_cycle  = 40;
    localparam int len_mixed  = 300;
    localparam int timeout_cycles =
        len_steady + len_stall + len_flush + len_cycle + len_mixed + 20;

    logic                   clk;
    logic                   rst;
    logic                   stall;
    logic                   flush;
    trace_pkg::fetch_obs_t  fetch_obs;
    trace_pkg::decode_obs_t decode_obs;
    trace_pkg::exec_obs_t   exec_obs;
    trace_pkg::mem_obs_t    mem_obs;
    trace_pkg::wb_obs_t     wb_obs;
    logic                   retire_valid;
    trace_pkg::retire_rec_t retire_rec;

    int error_count;
    int retire_count;
    int cycle_count;

    `include "trace_model.svh"

    pipeline_trace dut0 (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .fetch_obs    (fetch_obs),
        .decode_obs   (decode_obs),
        .exec_obs     (exec_obs),
        .mem_obs      (mem_obs),
        .wb_obs       (wb_obs),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit from the test lengths
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout: run did not complete within %0d cycles", timeout_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (act_v !== exp_v) begin
            $display("error %s expected %0h got %0h", name, exp_v, act_v);
            error_count++;
        end
    endtask

    // Fresh observations for every stage, stall and flush by percentage
    task automatic drive_inputs(input int stall_pct, input int flush_pct);
        fetch_obs.pc         <= $urandom;
        decode_obs.instr     <= $urandom;
        decode_obs.opcode    <= trace_pkg::opcode_e'(4'($urandom_range(6, 0)));
        exec_obs.alu_result  <= $urandom;
        mem_obs.addr         <= $urandom;
        mem_obs.accessed     <= 1'($urandom_range(1, 0));
        wb_obs.rd            <= 5'($urandom_range(31, 0));
        wb_obs.we            <= 1'($urandom_range(1, 0));
        wb_obs.data          <= $urandom;
        stall <= ($urandom_range(99, 0) < stall_pct);
        flush <= ($urandom_range(99, 0) < flush_pct);
    endtask

    task automatic run_test(input int num, input string name, input int cycles,
                            input int stall_pct, input int flush_pct);
        int err_start;
        int ret_start;
        err_start = error_count;
        ret_start = retire_count;
        repeat (cycles) begin
            @(posedge clk);
            model_step();
            drive_inputs(stall_pct, flush_pct);
        end
        $display("Test %0d %s: %0d retirements, %0d errors", num, name,
                 retire_count - ret_start, error_count - err_start);
    endtask

    //////////////////////////////////////////////////
    // Compare
    //////////////////////////////////////////////////

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        trace_pkg::retire_rec_t exp;
        if (!rst && retire_valid) begin
            if (exp_q.size() == 0) begin
                $display("Retire strobe in cycle %0d with no instruction due", m_cycle);
                error_count++;
            end else begin
                exp = exp_q.pop_front();
                if (m_cycle != exp.retire_cycle + 1) begin
                    $display("Retire of tag %0d came in cycle %0d, not one cycle after writeback",
                             exp.tag, m_cycle);
                    error_count++;
                end
                // Pipeline fill takes five quiet cycles
                if (retire_count == 0 && m_cycle != 5) begin
                    $display("First retire strobe came in cycle %0d instead of cycle 5", m_cycle);
                    error_count++;
                end
                check_value("retire_rec.tag", 64'(exp.tag), 64'(retire_rec.tag));
                check_value("retire_rec.fetch", 64'(exp.fetch), 64'(retire_rec.fetch));
                check_value("retire_rec.decode", 64'(exp.decode), 64'(retire_rec.decode));
                check_value("retire_rec.exec", 64'(exp.exec), 64'(retire_rec.exec));
                check_value("retire_rec.mem", 64'(exp.mem), 64'(retire_rec.mem));
                check_value("retire_rec.wb", 64'(exp.wb), 64'(retire_rec.wb));
                check_value("retire_rec.retire_cycle", 64'(exp.retire_cycle),
                            64'(retire_rec.retire_cycle));
                retire_count++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h75865826));
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        fetch_obs  = '0;
        decode_obs = '0;
        exec_obs   = '0;
        mem_obs    = '0;
        wb_obs     = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        drive_inputs(0, 0);
        model_reset();
        run_test(1, "steady flow", len_steady, 0, 0);
        run_test(2, "random stall", len_stall, 30, 0);
        run_test(3, "flush pulses", len_flush, 0, 15);
        run_test(4, "retire cycle", len_cycle, 20, 10);
        run_test(5, "mixed stall and flush", len_mixed, 25, 10);
        // Last queued record strobes before this edge
        @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected retirements never appeared", exp_q.size());
            error_count += exp_q.size();
        end
        $display("Retirements checked: %0d, errors: %0d", retire_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
+incdir+test
common/trace_pkg.sv
trace/trace_tag_pipe.sv
trace/trace_record_table.sv
trace/trace_retire.sv
rtl/pipeline_trace.sv
test/tb_pipeline_trace.sv

//--- run.sh
#!/bin/sh
# Build the pipeline trace testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal -f list.f \
    --top-module tb_pipeline_trace -o sim_trace > build.log 2>&1 &&
./obj_dir/sim_trace | tee sim.log &&
grep -q "^Simulation PASSED$" sim.log &&
echo "Run passed" || {
    echo "Run failed, see build.log and sim.log"
    exit 1
}
